// ==== compile.f ====
+incdir+sim
hw/video_cfg_pkg.sv
hw/video_beat_pkg.sv
hw/video_capture.sv
hw/video_bw_filter.sv
hw/video_color_expand.sv
hw/video_out_top.sv
sim/tb_video_out.sv

// ==== hw/video_beat_pkg.sv ====
package video_beat_pkg;

    import video_cfg_pkg::*;

    // Timing flags of one pixel with active-low blanking
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } sync_t;

    typedef struct packed {
        logic [GAME_CW-1:0] r;
        logic [GAME_CW-1:0] g;
        logic [GAME_CW-1:0] b;
    } game_rgb_t;

    // Filtered colour
    typedef struct packed {
        logic [ANA_CW-1:0] r;
        logic [ANA_CW-1:0] g;
        logic [ANA_CW-1:0] b;
    } ana_rgb_t;

    typedef struct packed {
        logic [OUT_CW-1:0] r;
        logic [OUT_CW-1:0] g;
        logic [OUT_CW-1:0] b;
    } out_rgb_t;

    // Raw beat from the game
    typedef struct packed {
        game_rgb_t rgb;
        sync_t     sync;
    } game_beat_t;

    typedef struct packed {
        game_rgb_t rgb;
        sync_t     sync;
        logic      de;
    } cap_beat_t;

    typedef struct packed {
        ana_rgb_t rgb;
        sync_t    sync;
        logic     de;
    } ana_beat_t;

    typedef struct packed {
        out_rgb_t rgb;
        sync_t    sync;
        logic     de;
    } out_beat_t;

endpackage

// ==== hw/video_bw_filter.sv ====
module video_bw_filter (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      bw_en,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  video_beat_pkg::cap_beat_t  in_beat,

    output logic                      out_valid,
    input  logic                      out_ready,
    output video_beat_pkg::ana_beat_t  out_beat
);

    import video_cfg_pkg::*;
    import video_beat_pkg::*;

    game_rgb_t prev_rgb;
    ana_beat_t next_beat;
    logic      accept;

    // Two-tap average without the divide, or plain doubling when bypassed.
    // Both paths land on the same scale so brightness does not jump.
    function automatic logic [ANA_CW-1:0] filt_ch(
        input logic [GAME_CW-1:0] cur,
        input logic [GAME_CW-1:0] prev,
        input logic               en
    );
        logic [ANA_CW-1:0] sum;
        logic [ANA_CW-1:0] dbl;
        sum = ANA_CW'(cur) + ANA_CW'(prev);
        dbl = {cur, 1'b0};
        return en ? sum : dbl;
    endfunction

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        next_beat.rgb.r = filt_ch(in_beat.rgb.r, prev_rgb.r, bw_en);
        next_beat.rgb.g = filt_ch(in_beat.rgb.g, prev_rgb.g, bw_en);
        next_beat.rgb.b = filt_ch(in_beat.rgb.b, prev_rgb.b, bw_en);
        next_beat.sync  = in_beat.sync;
        next_beat.de    = in_beat.de;
    end

    // Previous pixel follows accepted beats only.
    // Blank pixels arrive as zero, so each line starts from black.
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_valid <= 1'b0;
            prev_rgb  <= '0;
        end else begin
            if (accept) begin
                out_valid <= 1'b1;
                prev_rgb  <= in_beat.rgb;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            out_beat <= next_beat;
        end
    end

endmodule

// ==== hw/video_capture.sv ====
module video_capture (
    input  logic                      clk_sys,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  video_beat_pkg::game_beat_t in_beat,

    output logic                      out_valid,
    input  logic                      out_ready,
    output video_beat_pkg::cap_beat_t  out_beat
);

    import video_beat_pkg::*;

    cap_beat_t next_beat;
    logic      accept;

    // Single slot that is free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // Data enable only inside the visible area
    always_comb begin
        next_beat.sync = in_beat.sync;
        next_beat.de   = in_beat.sync.lhbl && in_beat.sync.lvbl;
        if (next_beat.de) begin
            next_beat.rgb = in_beat.rgb;
        end else begin
            // Black during blanking
            next_beat.rgb = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            out_beat <= next_beat;
        end
    end

endmodule

// ==== hw/video_cfg_pkg.sv ====
package video_cfg_pkg;

    // Colour depth as delivered by the game core
    localparam int GAME_CW = 4;

    // One extra bit of headroom after the bandwidth filter.
    // The sum of two game pixels needs exactly one more bit.
    localparam int ANA_CW = GAME_CW + 1;

    // Final per-channel width on the video output
    localparam int OUT_CW = 8;

endpackage

// ==== hw/video_color_expand.sv ====
module video_color_expand (
    input  logic                      clk_sys,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  video_beat_pkg::ana_beat_t  in_beat,

    output logic                      out_valid,
    input  logic                      out_ready,
    output video_beat_pkg::out_beat_t  out_beat
);

    import video_cfg_pkg::*;
    import video_beat_pkg::*;

    out_beat_t next_beat;
    logic      accept;

    // Fill the low bits with the top bits so full scale maps to full scale
    function automatic logic [OUT_CW-1:0] expand_ch(input logic [ANA_CW-1:0] ch);
        return {ch, ch[ANA_CW-1 -: OUT_CW-ANA_CW]};
    endfunction

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        next_beat.rgb.r = expand_ch(in_beat.rgb.r);
        next_beat.rgb.g = expand_ch(in_beat.rgb.g);
        next_beat.rgb.b = expand_ch(in_beat.rgb.b);
        next_beat.sync  = in_beat.sync;
        next_beat.de    = in_beat.de;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            out_beat <= next_beat;
        end
    end

endmodule

// ==== hw/video_out_top.sv ====
module video_out_top (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      bw_en,

    input  logic                      game_valid,
    output logic                      game_ready,
    input  video_beat_pkg::game_beat_t game_beat,

    output logic                      out_valid,
    input  logic                      out_ready,
    output video_beat_pkg::out_beat_t  out_beat
);

    import video_beat_pkg::*;

    logic      cap_valid;
    logic      cap_ready;
    cap_beat_t cap_beat;

    logic      ana_valid;
    logic      ana_ready;
    ana_beat_t ana_beat;

    // Blanking capture
    video_capture u_capture (
        .clk_sys   ( clk_sys    ),
        .reset     ( reset      ),
        .in_valid  ( game_valid ),
        .in_ready  ( game_ready ),
        .in_beat   ( game_beat  ),
        .out_valid ( cap_valid  ),
        .out_ready ( cap_ready  ),
        .out_beat  ( cap_beat   )
    );

    // Limited bandwidth for the video signal
    video_bw_filter u_bw_filter (
        .clk_sys   ( clk_sys    ),
        .reset     ( reset      ),
        .bw_en     ( bw_en      ),
        .in_valid  ( cap_valid  ),
        .in_ready  ( cap_ready  ),
        .in_beat   ( cap_beat   ),
        .out_valid ( ana_valid  ),
        .out_ready ( ana_ready  ),
        .out_beat  ( ana_beat   )
    );

    // 15bpp to 24bpp
    video_color_expand u_color_expand (
        .clk_sys   ( clk_sys    ),
        .reset     ( reset      ),
        .in_valid  ( ana_valid  ),
        .in_ready  ( ana_ready  ),
        .in_beat   ( ana_beat   ),
        .out_valid ( out_valid  ),
        .out_ready ( out_ready  ),
        .out_beat  ( out_beat   )
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the video output testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

# A failed build or a crashed run counts as a failure too
verilator --binary --timing -j 0 --top-module tb_video_out -f compile.f \
    -Mdir obj_dir -o tb_video_out > "$log" 2>&1 \
    && ./obj_dir/tb_video_out >> "$log" 2>&1 \
    || echo "Done: errors found" >> "$log"

if grep -q "Done: errors found" "$log"; then
    echo "Simulation FAILED, see $log"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== sim/tb_video_out_checks.svh ====
`ifndef TB_VIDEO_OUT_CHECKS_SVH
`define TB_VIDEO_OUT_CHECKS_SVH

// Print the verdict and end the run at the first failure
task automatic stop_on_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic report_mismatch(input string msg);
    $display("error at time %0t: %s", $time, msg);
    stop_on_failure();
endtask

task automatic report_timeout(input string msg);
    $display("%s (at time %0t)", msg, $time);
    stop_on_failure();
endtask

// Colour of one output beat
task automatic check_rgb(input out_rgb_t got, input out_rgb_t expected, input string what);
    if (got !== expected) begin
        report_mismatch($sformatf("%s colour got %02h_%02h_%02h, expected %02h_%02h_%02h",
                                  what, got.r, got.g, got.b,
                                  expected.r, expected.g, expected.b));
    end
endtask

// Timing flags travel untouched through all stages
task automatic check_sync(input sync_t got, input sync_t expected, input string what);
    if (got !== expected) begin
        report_mismatch($sformatf("%s sync got %b, expected %b (hs vs lhbl lvbl)",
                                  what, got, expected));
    end
endtask

task automatic check_bit(input logic got, input logic expected, input string what);
    if (got !== expected) begin
        report_mismatch($sformatf("%s got %b, expected %b", what, got, expected));
    end
endtask

// Latency in cycles
task automatic check_count(input int got, input int expected, input string what);
    if (got != expected) begin
        report_mismatch($sformatf("%s got %0d, expected %0d", what, got, expected));
    end
endtask

`endif

// ==== sim/tb_video_out.sv ====
module tb_video_out;

    import video_beat_pkg::*;

    localparam int          NUM_DIRECTED   = 12;
    localparam int          NUM_RANDOM     = 40;
    localparam int          NUM_ROWS       = NUM_DIRECTED + NUM_RANDOM;
    localparam int          ACCEPT_TIMEOUT = 100;
    localparam int          DRAIN_TIMEOUT  = 200;
    localparam logic [31:0] RNG_SEED       = 32'd66198;

    typedef struct packed {
        game_beat_t beat;
        logic       bw_en;
    } stim_row_t;

    logic       clk_sys = 1'b0;
    logic       reset;
    logic       bw_en;
    logic       game_valid;
    logic       game_ready;
    game_beat_t game_beat;
    logic       out_valid;
    logic       out_ready = 1'b0;
    out_beat_t  out_beat;

    stim_row_t   stim_table [NUM_ROWS];
    logic [31:0] ready_rng = RNG_SEED;
    logic        hold_ready;
    logic        check_latency;

    // Reference model state and the beats in flight
    game_rgb_t model_prev = '0;
    out_beat_t exp_q [$];
    int        acc_cycle_q [$];
    int        idx_q [$];
    int        accept_count = 0;
    int        cycle_count = 0;

    `include "tb_video_out_checks.svh"

    video_out_top uut (
        .clk_sys    ( clk_sys    ),
        .reset      ( reset      ),
        .bw_en      ( bw_en      ),
        .game_valid ( game_valid ),
        .game_ready ( game_ready ),
        .game_beat  ( game_beat  ),
        .out_valid  ( out_valid  ),
        .out_ready  ( out_ready  ),
        .out_beat   ( out_beat   )
    );

    always #20 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic stim_row_t make_row(
        input logic [3:0] r,
        input logic [3:0] g,
        input logic [3:0] b,
        input logic       hs,
        input logic       vs,
        input logic       lhbl,
        input logic       lvbl,
        input logic       bw
    );
        stim_row_t row;
        row.beat.rgb.r     = r;
        row.beat.rgb.g     = g;
        row.beat.rgb.b     = b;
        row.beat.sync.hs   = hs;
        row.beat.sync.vs   = vs;
        row.beat.sync.lhbl = lhbl;
        row.beat.sync.lvbl = lvbl;
        row.bw_en          = bw;
        return row;
    endfunction

    // Sum with the previous pixel, or double when the filter is off
    function automatic int filter_channel(input int cur, input int prev, input logic bw);
        if (bw) begin
            return cur + prev;
        end
        return 2 * cur;
    endfunction

    // Widen 5 bits to 8 so full scale maps to full scale
    function automatic logic [7:0] widen_channel(input int f);
        int wide;
        wide = (f * 8) + (f / 4);
        return 8'(wide);
    endfunction

    task automatic model_beat(input game_beat_t beat, input logic bw, output out_beat_t expected);
        game_rgb_t cur;
        logic      de;
        de = beat.sync.lhbl & beat.sync.lvbl;
        if (de) begin
            cur = beat.rgb;
        end else begin
            cur = '0;
        end
        expected.rgb.r = widen_channel(filter_channel(int'(cur.r), int'(model_prev.r), bw));
        expected.rgb.g = widen_channel(filter_channel(int'(cur.g), int'(model_prev.g), bw));
        expected.rgb.b = widen_channel(filter_channel(int'(cur.b), int'(model_prev.b), bw));
        expected.sync  = beat.sync;
        expected.de    = de;
        model_prev     = cur;
    endtask

    task automatic build_table();
        logic [31:0] x;
        x = RNG_SEED;
        // With the filter off 0xF doubles to 0x1E and widens to 0xF7
        stim_table[0]  = make_row(4'hF, 4'h0, 4'h8, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        stim_table[1]  = make_row(4'h3, 4'h7, 4'h1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        stim_table[2]  = make_row(4'h5, 4'h5, 4'h5, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        // With the filter on the first active pixel after blanking sums with black
        stim_table[3]  = make_row(4'hA, 4'hA, 4'hA, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        stim_table[4]  = make_row(4'h6, 4'h2, 4'hF, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        stim_table[5]  = make_row(4'h9, 4'h4, 4'h1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        stim_table[6]  = make_row(4'hF, 4'hF, 4'hF, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        stim_table[7]  = make_row(4'hC, 4'hC, 4'hC, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        stim_table[8]  = make_row(4'h1, 4'h2, 4'h3, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        // Vertical blank with vs set
        stim_table[9]  = make_row(4'h7, 4'h7, 4'h7, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        stim_table[10] = make_row(4'h8, 4'h8, 4'h8, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        stim_table[11] = make_row(4'hF, 4'hF, 4'hF, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        // Random rows in blocks of ten with the same filter setting
        for (int i = 0; i < NUM_RANDOM; i++) begin
            x = xorshift32(x);
            stim_table[NUM_DIRECTED + i] = make_row(x[3:0], x[7:4], x[11:8], x[12], x[13],
                                                    x[17:16] != 2'b00, x[19:18] != 2'b00,
                                                    ((i / 10) % 2) == 1);
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                report_timeout("Timeout: the pipeline did not deliver all accepted beats");
            end
            @(negedge clk_sys);
            waited++;
        end
    endtask

    // Present one row and hold it until the DUT takes it
    task automatic send_row(input stim_row_t row, input int idx);
        int start_count;
        int waited;
        // The filter setting only changes with the pipeline empty
        if (row.bw_en !== bw_en) begin
            wait_for_drain();
            bw_en = row.bw_en;
        end
        start_count = accept_count;
        game_beat   = row.beat;
        game_valid  = 1'b1;
        waited      = 0;
        @(negedge clk_sys);
        while (accept_count == start_count) begin
            if (waited >= ACCEPT_TIMEOUT) begin
                report_timeout($sformatf("Timeout: row %0d was never accepted by the DUT", idx));
            end
            @(negedge clk_sys);
            waited++;
        end
        game_valid = 1'b0;
    endtask

    // Random back-pressure
    always @(negedge clk_sys) begin
        if (hold_ready) begin
            out_ready <= 1'b1;
        end else begin
            ready_rng = xorshift32(ready_rng);
            out_ready <= (ready_rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk_sys) begin : transfer_monitor
        out_beat_t expected;
        int        acc_cycle;
        int        idx;
        if (!reset) begin
            if (out_valid && exp_q.size() == 0) begin
                report_mismatch("out_valid high with no beat in flight");
            end
            if (out_valid && out_ready) begin
                expected  = exp_q.pop_front();
                acc_cycle = acc_cycle_q.pop_front();
                idx       = idx_q.pop_front();
                check_rgb(out_beat.rgb, expected.rgb, $sformatf("beat %0d", idx));
                check_sync(out_beat.sync, expected.sync, $sformatf("beat %0d", idx));
                check_bit(out_beat.de, expected.de, $sformatf("beat %0d de", idx));
                if (check_latency) begin
                    check_count(cycle_count - acc_cycle, 3, "lone beat latency in cycles");
                end
            end
            if (game_valid && game_ready) begin
                model_beat(game_beat, bw_en, expected);
                exp_q.push_back(expected);
                acc_cycle_q.push_back(cycle_count);
                idx_q.push_back(accept_count);
                accept_count++;
            end
        end
        cycle_count++;
    end

    initial begin
        reset         = 1'b1;
        bw_en         = 1'b0;
        game_valid    = 1'b0;
        game_beat     = '0;
        hold_ready    = 1'b0;
        check_latency = 1'b0;
        build_table();

        repeat (5) @(negedge clk_sys);
        reset = 1'b0;

        // Empty pipeline right after reset
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(game_ready, 1'b1, "game_ready after reset");
        repeat (4) begin
            @(negedge clk_sys);
            check_bit(out_valid, 1'b0, "out_valid while idle");
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(stim_table[i], i);
        end
        wait_for_drain();

        // Lone beat with out_ready held high
        hold_ready = 1'b1;
        repeat (2) @(negedge clk_sys);
        check_latency = 1'b1;
        send_row(make_row(4'h4, 4'hB, 4'h2, 1'b0, 1'b0, 1'b1, 1'b1, bw_en), NUM_ROWS);
        wait_for_drain();
        check_latency = 1'b0;

        // No extra beat once every accepted beat has come out
        repeat (4) begin
            @(negedge clk_sys);
            check_bit(out_valid, 1'b0, "out_valid after the last beat");
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
